/* src/spart_pkg.sv */
`default_nettype none

package spart_pkg;

    // register map seen by the processor
    typedef enum logic [1:0] {
        ADDR_DATA   = 2'd0,
        ADDR_STATUS = 2'd1,
        ADDR_DB_LO  = 2'd2,
        ADDR_DB_HI  = 2'd3
    } spart_addr_e;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

    // flag positions in the status byte
    localparam int STAT_RDA_BIT = 0;
    localparam int STAT_TBR_BIT = 1;

    localparam int OVERSAMPLE = 16;             // enables per serial bit
    localparam int SMP_W      = $clog2(OVERSAMPLE);

    localparam int              DIV_W           = 16;
    localparam logic [DIV_W-1:0] DEFAULT_DIVISOR = 16'd15;

endpackage

`default_nettype wire

/* src/spart_chan_if.sv */
`default_nettype none

interface spart_chan_if;

    logic [7:0] tx_data;    // byte to send
    logic       tx_load;    // one-cycle load strobe
    logic       tbr;        // transmit buffer ready
    logic [7:0] rx_data;    // last received byte
    logic       rda;        // receive data available
    logic       rx_clear;   // data register was read

    modport ctrl (
        output tx_data, tx_load, rx_clear,
        input  tbr, rx_data, rda
    );

    modport rx (input rx_clear, output rx_data, rda);

    modport tx (input tx_data, tx_load, output tbr);

endinterface

`default_nettype wire

/* src/spart_baud_gen.sv */
`default_nettype none

module spart_baud_gen (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire  [spart_pkg::DIV_W-1:0] divisor,
    input  wire                         div_wr,
    output logic                        baud_en
);
    import spart_pkg::*;

    logic [DIV_W-1:0] cnt;
    logic             cnt_zero;

    assign cnt_zero = (cnt == '0);

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= '0;
            baud_en <= 1'b0;
        end else begin
            // a new divisor restarts the period
            if (div_wr || cnt_zero)
                cnt <= divisor;
            else
                cnt <= cnt - 1'b1;

            baud_en <= cnt_zero && !div_wr;     // one pulse per divisor+1 clocks
        end
    end

endmodule

`default_nettype wire

/* src/spart_rx.sv */
`default_nettype none

module spart_rx (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         baud_en,    // 16x bit rate
    input  wire         rxd,
    spart_chan_if.rx    chan
);
    import spart_pkg::*;

    rx_state_e        state, state_nxt;
    logic             rxd_meta, rxd_s;
    logic [SMP_W-1:0] sample_cnt;
    logic [2:0]       bit_cnt;
    logic [7:0]       shift_reg;
    logic             mid_bit, end_bit;
    logic             cnt_clr, shift, load;

    // double synchronizer that idles high like the line
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_s    <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_s    <= rxd_meta;
        end
    end

    assign mid_bit = baud_en && (sample_cnt == SMP_W'(OVERSAMPLE/2 - 1));
    assign end_bit = baud_en && (sample_cnt == SMP_W'(OVERSAMPLE - 1));

    always_comb begin
        state_nxt = state;
        cnt_clr   = 1'b0;
        shift     = 1'b0;
        load      = 1'b0;
        case (state)
            RX_IDLE: begin
                if (!rxd_s && !chan.rda) begin  // falling edge with the buffer free
                    state_nxt = RX_START;
                    cnt_clr   = 1'b1;
                end
            end
            RX_START: begin
                if (mid_bit) begin
                    cnt_clr   = 1'b1;           // later samples land mid-bit
                    state_nxt = rxd_s ? RX_IDLE : RX_DATA;  // glitch check
                end
            end
            RX_DATA: begin
                if (end_bit) begin
                    shift = 1'b1;
                    if (bit_cnt == 3'd7)
                        state_nxt = RX_STOP;
                end
            end
            default: begin
                if (end_bit) begin
                    state_nxt = RX_IDLE;
                    load      = rxd_s;          // framing error drops the byte
                end
            end
        endcase
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state      <= RX_IDLE;
            sample_cnt <= '0;
            bit_cnt    <= '0;
            chan.rda   <= 1'b0;
        end else begin
            state <= state_nxt;
            if (cnt_clr)
                sample_cnt <= '0;
            else if (baud_en)
                sample_cnt <= sample_cnt + 1'b1;    // wraps every bit
            if (cnt_clr)
                bit_cnt <= '0;
            else if (shift)
                bit_cnt <= bit_cnt + 1'b1;
            if (load)
                chan.rda <= 1'b1;
            else if (chan.rx_clear)
                chan.rda <= 1'b0;
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (shift)
            shift_reg <= {rxd_s, shift_reg[7:1]};
        if (load)
            chan.rx_data <= shift_reg;
    end

endmodule

`default_nettype wire

/* src/spart_tx.sv */
`default_nettype none

module spart_tx (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         baud_en,
    output logic        txd,
    spart_chan_if.tx    chan
);
    import spart_pkg::*;

    tx_state_e        state, state_nxt;
    logic [SMP_W-1:0] sample_cnt;
    logic [2:0]       bit_cnt;
    logic [7:0]       shift_reg;
    logic             bit_start, bit_done;
    logic             line_bit;

    assign bit_start = baud_en && (sample_cnt == '0);
    assign bit_done  = baud_en && (sample_cnt == SMP_W'(OVERSAMPLE - 1));

    assign chan.tbr = (state == TX_IDLE);

    always_comb begin
        state_nxt = state;
        case (state)
            TX_IDLE:  if (chan.tx_load) state_nxt = TX_START;
            TX_START: if (bit_done) state_nxt = TX_DATA;
            TX_DATA:  if (bit_done && bit_cnt == 3'd7) state_nxt = TX_STOP;
            default:  if (bit_done) state_nxt = TX_IDLE;
        endcase
    end

    // level to put on the line for this state
    always_comb begin
        case (state)
            TX_START: line_bit = 1'b0;
            TX_DATA:  line_bit = shift_reg[0];
            default:  line_bit = 1'b1;          // stop bit and idle
        endcase
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state      <= TX_IDLE;
            sample_cnt <= '0;
            bit_cnt    <= '0;
            txd        <= 1'b1;
        end else begin
            state <= state_nxt;
            if (state == TX_IDLE)
                sample_cnt <= '0;               // frame waits for the next enable
            else if (baud_en)
                sample_cnt <= sample_cnt + 1'b1;
            if (state == TX_START)
                bit_cnt <= '0;
            else if (state == TX_DATA && bit_done)
                bit_cnt <= bit_cnt + 1'b1;
            if (bit_start && state != TX_IDLE)
                txd <= line_bit;
        end
    end

    always_ff @(posedge clk) begin
        if (state == TX_IDLE && chan.tx_load)
            shift_reg <= chan.tx_data;
        else if (state == TX_DATA && bit_done)
            shift_reg <= shift_reg >> 1;        // next data bit to bit 0
    end

endmodule

`default_nettype wire

/* src/spart_bus_ctrl.sv */
`default_nettype none

module spart_bus_ctrl (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         iocs,
    input  wire                         iorw,       // 1 reads
    input  wire spart_pkg::spart_addr_e addr,
    input  wire  [7:0]                  databus_in,
    output logic [7:0]                  databus_out,
    output logic [spart_pkg::DIV_W-1:0] divisor,
    output logic                        div_wr,
    spart_chan_if.ctrl                  chan
);
    import spart_pkg::*;

    logic rd, wr;
    logic wr_lo, wr_hi;

    assign rd    = iocs && iorw;
    assign wr    = iocs && !iorw;
    assign wr_lo = wr && (addr == ADDR_DB_LO);
    assign wr_hi = wr && (addr == ADDR_DB_HI);

    // strobes toward the serial engines
    assign chan.tx_data  = databus_in;
    assign chan.tx_load  = wr && (addr == ADDR_DATA) && chan.tbr;   // busy drops it
    assign chan.rx_clear = rd && (addr == ADDR_DATA);

    always_comb begin
        databus_out = '0;
        if (rd) begin
            case (addr)
                ADDR_DATA:   databus_out = chan.rx_data;
                ADDR_STATUS: begin
                    databus_out[STAT_RDA_BIT] = chan.rda;
                    databus_out[STAT_TBR_BIT] = chan.tbr;
                end
                ADDR_DB_LO:  databus_out = divisor[7:0];
                default:     databus_out = divisor[DIV_W-1:8];
            endcase
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            divisor <= DEFAULT_DIVISOR;
            div_wr  <= 1'b0;
        end else begin
            if (wr_lo)
                divisor[7:0] <= databus_in;
            if (wr_hi)
                divisor[DIV_W-1:8] <= databus_in;
            // delayed a cycle so the generator sees the new value
            div_wr <= wr_lo || wr_hi;
        end
    end

endmodule

`default_nettype wire

/* src/spart.sv */
`default_nettype none

module spart (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         iocs,
    input  wire         iorw,
    input  wire  [1:0]  addr,
    input  wire  [7:0]  databus_in,
    output logic [7:0]  databus_out,
    input  wire         rxd,
    output logic        txd
);
    import spart_pkg::*;

    logic [DIV_W-1:0] divisor;
    logic             div_wr;
    logic             baud_en;      // 16x bit rate tick

    spart_chan_if chan ();

    spart_bus_ctrl bus_ctrl0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .iocs        (iocs),
        .iorw        (iorw),
        .addr        (spart_addr_e'(addr)),
        .databus_in  (databus_in),
        .databus_out (databus_out),
        .divisor     (divisor),
        .div_wr      (div_wr),
        .chan        (chan.ctrl)
    );

    spart_baud_gen baud_gen0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .divisor (divisor),
        .div_wr  (div_wr),
        .baud_en (baud_en)
    );

    spart_rx rx0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .baud_en (baud_en),
        .rxd     (rxd),
        .chan    (chan.rx)
    );

    spart_tx tx0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .baud_en (baud_en),
        .txd     (txd),
        .chan    (chan.tx)
    );

endmodule

`default_nettype wire

/* tests/spart_properties.sv */
`default_nettype none

module spart_props (
    input wire       clk,
    input wire       rst_n,
    input wire       baud_en,
    input wire       txd,
    input wire       tbr,
    input wire       rda,
    input wire       iocs,
    input wire       iorw,
    input wire [1:0] addr
);
    timeunit 1ns;
    timeprecision 1ps;
    import spart_pkg::*;

    int failures = 0;   // read back by the testbench at the end

    // the 16x tick lasts one clock
    baud_en_pulse: assert property (@(posedge clk) disable iff (!rst_n) baud_en |=> !baud_en)
        else begin
            failures++;
            $error("baud_en high for two cycles in a row");
        end

    idle_line_high: assert property (@(posedge clk) disable iff (!rst_n) tbr |-> txd)
        else begin
            failures++;
            $error("txd low while TBR is set");
        end

    rda_clear_on_read: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(rda) |-> $past(iocs && iorw && addr == ADDR_DATA))
        else begin
            failures++;
            $error("RDA fell without a read of the data register");
        end

endmodule

bind spart spart_props props0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .baud_en (baud_en),
    .txd     (txd),
    .tbr     (chan.tbr),
    .rda     (chan.rda),
    .iocs    (iocs),
    .iorw    (iorw),
    .addr    (addr)
);

`default_nettype wire

/* tests/spart_clk_gen.sv */
`default_nettype none

module spart_clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;     // 20 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* tests/spart_tb.sv */
`default_nettype none

module spart_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import spart_pkg::*;

    logic       clk;
    logic       rst_n;
    logic       iocs;
    logic       iorw;
    logic [1:0] addr;
    logic [7:0] databus_in;
    logic [7:0] databus_out;
    logic       rxd;
    logic       txd;

    int errors;
    int checks;
    int bit_clks;   // clocks per serial bit

    spart_clk_gen clk_gen0 (.clk(clk), .rst_n(rst_n));

    spart dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .iocs        (iocs),
        .iorw        (iorw),
        .addr        (addr),
        .databus_in  (databus_in),
        .databus_out (databus_out),
        .rxd         (rxd),
        .txd         (txd)
    );

    task automatic compare_byte(input string name, input logic [7:0] got,
                                input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %02h expected %02h", $time, name, got, exp);
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout %s, %0d checks, %0d errors", what, checks, errors);
        $display("TEST FAIL");
        $finish;
    endtask

    task automatic bus_write(input spart_addr_e a, input logic [7:0] d);
        @(posedge clk);
        iocs       <= 1'b1;
        iorw       <= 1'b0;
        addr       <= a;
        databus_in <= d;
        @(posedge clk);
        iocs <= 1'b0;
    endtask

    task automatic bus_read(input spart_addr_e a, output logic [7:0] d);
        @(posedge clk);
        iocs <= 1'b1;
        iorw <= 1'b1;
        addr <= a;
        @(negedge clk);
        d = databus_out;    // settled mid-cycle
        @(posedge clk);
        iocs <= 1'b0;
    endtask

    function automatic logic [7:0] status_byte(input logic rda, input logic tbr);
        logic [7:0] s;
        s = '0;
        s[STAT_RDA_BIT] = rda;
        s[STAT_TBR_BIT] = tbr;
        return s;
    endfunction

    // poll status until one flag reaches the wanted level
    task automatic wait_flag(input int bit_pos, input logic level, input string what);
        logic [7:0] s;
        for (int n = 0; n < 10 * bit_clks; n++) begin
            bus_read(ADDR_STATUS, s);
            if (s[bit_pos] === level)
                return;
        end
        give_up(what);
    endtask

    task automatic set_divisor(input logic [15:0] div);
        bus_write(ADDR_DB_LO, div[7:0]);
        bus_write(ADDR_DB_HI, div[15:8]);
        bit_clks = OVERSAMPLE * (int'(div) + 1);
    endtask

    // stop level held for three quarters of its bit before the line idles
    task automatic send_frame(input logic [7:0] d, input logic stop);
        logic [8:0] bits;
        bits = {d, 1'b0};
        for (int i = 0; i < 9; i++) begin
            rxd <= bits[i];     // start bit then lsb first
            repeat (bit_clks) @(posedge clk);
        end
        rxd <= stop;
        repeat (bit_clks * 3 / 4) @(posedge clk);
        rxd <= 1'b1;
        repeat (bit_clks - bit_clks * 3 / 4) @(posedge clk);
    endtask

    // serial monitor that samples each bit of a txd frame at its middle
    task automatic receive_frame(output logic [7:0] d);
        int n;
        n = 0;
        @(negedge clk);
        while (txd !== 1'b0 && n < 4 * bit_clks) begin
            n++;
            @(negedge clk);
        end
        if (txd !== 1'b0)
            give_up("waiting for a start bit on txd");
        repeat (bit_clks / 2) @(negedge clk);
        compare_byte("txd start bit", {7'd0, txd}, 8'h00);
        for (int i = 0; i < 8; i++) begin
            repeat (bit_clks) @(negedge clk);
            d[i] = txd;
        end
        repeat (bit_clks) @(negedge clk);
        compare_byte("txd stop bit", {7'd0, txd}, 8'h01);
    endtask

    task automatic rx_bytes(input int count);
        logic [7:0] d;
        logic [7:0] got;
        repeat (count) begin
            d = 8'($urandom);
            send_frame(d, 1'b1);
            wait_flag(STAT_RDA_BIT, 1'b1, "waiting for RDA");
            bus_read(ADDR_DATA, got);
            compare_byte("databus_out", got, d);
            bus_read(ADDR_STATUS, got);
            compare_byte("status", got, status_byte(1'b0, 1'b1));
        end
    endtask

    task automatic tx_bytes(input int count);
        logic [7:0] d;
        logic [7:0] got;
        logic [7:0] seen;
        repeat (count) begin
            d = 8'($urandom);
            wait_flag(STAT_TBR_BIT, 1'b1, "waiting for TBR");
            fork
                receive_frame(seen);
                begin
                    bus_write(ADDR_DATA, d);
                    bus_read(ADDR_STATUS, got);
                    compare_byte("status", got, status_byte(1'b0, 1'b0));    // busy
                end
            join
            compare_byte("txd byte", seen, d);
        end
        wait_flag(STAT_TBR_BIT, 1'b1, "waiting for TBR after the last frame");
    endtask

    initial begin
        logic [7:0] got;
        logic [7:0] first;
        int         n;
        iocs       = 1'b0;
        iorw       = 1'b0;
        addr       = '0;
        databus_in = '0;
        rxd        = 1'b1;
        errors     = 0;
        checks     = 0;
        bit_clks   = OVERSAMPLE * (int'(DEFAULT_DIVISOR) + 1);
        void'($urandom(45));

        for (n = 0; n < 40 && rst_n !== 1'b1; n++)
            @(posedge clk);
        if (rst_n !== 1'b1)
            give_up("waiting for reset release");

        compare_byte("txd", {7'd0, txd}, 8'h01);
        compare_byte("databus_out", databus_out, 8'h00);    // no read in progress
        bus_read(ADDR_STATUS, got);
        compare_byte("status", got, status_byte(1'b0, 1'b1));

        set_divisor(16'd3);
        rx_bytes(20);
        tx_bytes(20);

        // a framing error delivers nothing
        send_frame(8'($urandom), 1'b0);
        repeat (10 * bit_clks) @(posedge clk);
        bus_read(ADDR_STATUS, got);
        compare_byte("status", got, status_byte(1'b0, 1'b1));

        // second frame lands while the first byte is still unread
        first = 8'($urandom);
        send_frame(first, 1'b1);
        wait_flag(STAT_RDA_BIT, 1'b1, "waiting for RDA");
        send_frame(~first, 1'b1);
        bus_read(ADDR_DATA, got);
        compare_byte("databus_out", got, first);
        repeat (10 * bit_clks) @(posedge clk);
        bus_read(ADDR_STATUS, got);
        compare_byte("status", got, status_byte(1'b0, 1'b1));

        set_divisor(16'd7);
        rx_bytes(5);
        tx_bytes(5);

        errors += dut0.props0.failures;     // bound assertion failures
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
src/spart_pkg.sv
src/spart_chan_if.sv
src/spart_baud_gen.sv
src/spart_rx.sv
src/spart_tx.sv
src/spart_bus_ctrl.sv
src/spart.sv
tests/spart_properties.sv
tests/spart_clk_gen.sv
tests/spart_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f build.f --top-module spart_tb || exit 1
out=$(./obj_dir/Vspart_tb +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -qx 'TEST PASS' && echo "run passed" || { echo "run failed"; exit 1; }
